// File: smartnic_host_consts.svh
`ifndef SMARTNIC_HOST_CONSTS_SVH
`define SMARTNIC_HOST_CONSTS_SVH

// ----------------------------------------
// stream beat
// ----------------------------------------
`define DATA_W 64
`define KEEP_W 8

// ----------------------------------------
// host queue ids
// ----------------------------------------
`define QID_W 12

// PF, VF0, VF1, VF2
`define NUM_RANGES 4

// saturates at all ones
`define FAIL_CNT_W 16

`endif

// File: smartnic_host_pkg.sv
`default_nettype none

package smartnic_host_pkg;

    // cmac port this traffic belongs to
    typedef enum logic [0:0] {
        P0 = 1'b0,
        P1 = 1'b1
    } port_num_e;

    // host function type
    typedef enum logic [1:0] {
        PF  = 2'd0,
        VF0 = 2'd1,
        VF1 = 2'd2,
        VF2 = 2'd3
    } port_typ_e;

    // port tag carried as tid
    // encoded view for steering, raw view on the external streams
    typedef union packed {
        struct packed {
            port_num_e num;
            port_typ_e typ;
        } encoded;
        logic [2:0] raw;
    } port_t;

endpackage

`default_nettype wire

// File: host_q_classify.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_host_consts.svh"

module host_q_classify #(
    parameter int HOST_PORT = 0
) (
    input  logic                        core_clk,
    input  logic                        srst,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`DATA_W-1:0]          in_data,
    input  logic [`KEEP_W-1:0]          in_keep,
    input  logic                        in_last,
    input  logic [`QID_W-1:0]           in_qid,

    input  logic [`QID_W-1:0]           q_base [`NUM_RANGES],
    input  logic [`QID_W-1:0]           q_num  [`NUM_RANGES],

    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`DATA_W-1:0]          out_data,
    output logic [`KEEP_W-1:0]          out_keep,
    output logic                        out_last,
    output smartnic_host_pkg::port_t    out_tid,

    output logic [`FAIL_CNT_W-1:0]      fail_cnt
);

    logic [`NUM_RANGES-1:0]         hit;
    smartnic_host_pkg::port_typ_e   hit_typ;
    logic                           in_sop;
    logic                           pkt_ok;
    smartnic_host_pkg::port_typ_e   pkt_typ;
    logic                           cur_ok;
    smartnic_host_pkg::port_typ_e   cur_typ;
    logic                           in_fire;

    // ----------------------------------------
    // range check
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < `NUM_RANGES; i++) begin
            // 13-bit compare so base + num cannot wrap
            hit[i] = (in_qid >= q_base[i]) &&
                     ({1'b0, in_qid} < ({1'b0, q_base[i]} + {1'b0, q_num[i]}));
        end
    end

    // lowest-numbered hit wins
    always_comb begin
        hit_typ = smartnic_host_pkg::VF2;
        for (int i = `NUM_RANGES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_typ = smartnic_host_pkg::port_typ_e'(2'(i));
            end
        end
    end

    // decision from first beat, held for the rest
    assign cur_ok  = in_sop ? (|hit) : pkt_ok;
    assign cur_typ = in_sop ? hit_typ : pkt_typ;

    // discarded beats never wait on the output register
    assign in_ready = !cur_ok || !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            in_sop   <= 1'b1;
            pkt_ok   <= 1'b0;
            pkt_typ  <= smartnic_host_pkg::PF;
            fail_cnt <= '0;
        end else if (in_fire) begin
            in_sop  <= in_last;
            pkt_ok  <= cur_ok;
            pkt_typ <= cur_typ;
            if (!cur_ok && in_last && (fail_cnt != '1)) begin
                fail_cnt <= fail_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            out_valid <= 1'b0;
        end else if (in_fire && cur_ok) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_fire && cur_ok) begin
            out_data            <= in_data;
            out_keep            <= in_keep;
            out_last            <= in_last;
            out_tid.encoded.num <= smartnic_host_pkg::port_num_e'(1'(HOST_PORT));
            out_tid.encoded.typ <= cur_typ;
        end
    end

endmodule

`default_nettype wire

// File: pkt_arb_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_host_consts.svh"

module pkt_arb_mux (
    input  logic                        core_clk,
    input  logic                        srst,

    input  logic                        a_valid,
    output logic                        a_ready,
    input  logic [`DATA_W-1:0]          a_data,
    input  logic [`KEEP_W-1:0]          a_keep,
    input  logic                        a_last,
    input  smartnic_host_pkg::port_t    a_tid,

    input  logic                        b_valid,
    output logic                        b_ready,
    input  logic [`DATA_W-1:0]          b_data,
    input  logic [`KEEP_W-1:0]          b_keep,
    input  logic                        b_last,
    input  smartnic_host_pkg::port_t    b_tid,

    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`DATA_W-1:0]          out_data,
    output logic [`KEEP_W-1:0]          out_keep,
    output logic                        out_last,
    output smartnic_host_pkg::port_t    out_tid
);

    // sel: 0 picks input a, 1 picks input b
    logic locked;
    logic lock_sel;
    logic last_b;
    logic sel;

    // ----------------------------------------
    // grant
    // ----------------------------------------
    always_comb begin
        if (locked) begin
            sel = lock_sel;
        end else if (a_valid && b_valid) begin
            sel = !last_b;
        end else begin
            sel = b_valid && !a_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (srst) begin
            locked   <= 1'b0;
            lock_sel <= 1'b0;
            // pretend b went last so a wins the first tie
            last_b   <= 1'b1;
        end else if (out_valid && out_ready) begin
            if (out_last) begin
                locked <= 1'b0;
                last_b <= sel;
            end else begin
                locked   <= 1'b1;
                lock_sel <= sel;
            end
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    assign a_ready   = !sel && out_ready;
    assign b_ready   = sel && out_ready;
    assign out_valid = sel ? b_valid : a_valid;
    assign out_data  = sel ? b_data  : a_data;
    assign out_keep  = sel ? b_keep  : a_keep;
    assign out_last  = sel ? b_last  : a_last;
    assign out_tid   = sel ? b_tid   : a_tid;

endmodule

`default_nettype wire

// File: host_core_steer.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_host_consts.svh"

module host_core_steer (
    input  logic                        core_clk,
    input  logic                        srst,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`DATA_W-1:0]          in_data,
    input  logic [`KEEP_W-1:0]          in_keep,
    input  logic                        in_last,
    input  smartnic_host_pkg::port_t    in_tid,

    output logic                        main_valid,
    input  logic                        main_ready,
    output logic [`DATA_W-1:0]          main_data,
    output logic [`KEEP_W-1:0]          main_keep,
    output logic                        main_last,
    output smartnic_host_pkg::port_t    main_tid,

    output logic                        aux_valid,
    input  logic                        aux_ready,
    output logic [`DATA_W-1:0]          aux_data,
    output logic [`KEEP_W-1:0]          aux_keep,
    output logic                        aux_last,
    output smartnic_host_pkg::port_t    aux_tid
);

    logic                       in_sop;
    logic                       cur_aux;
    logic                       slot_valid;
    logic                       slot_aux;
    logic                       slot_ready;
    logic [`DATA_W-1:0]         slot_data;
    logic [`KEEP_W-1:0]         slot_keep;
    logic                       slot_last;
    smartnic_host_pkg::port_t   slot_tid;

    // VF2 goes to aux, everything else to main
    // mid-packet the slot still holds this packet's target
    assign cur_aux = in_sop ? (in_tid.encoded.typ == smartnic_host_pkg::VF2) : slot_aux;

    assign slot_ready = slot_aux ? aux_ready : main_ready;
    assign in_ready   = !slot_valid || slot_ready;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            in_sop     <= 1'b1;
            slot_valid <= 1'b0;
            slot_aux   <= 1'b0;
        end else if (in_valid && in_ready) begin
            in_sop     <= in_last;
            slot_valid <= 1'b1;
            slot_aux   <= cur_aux;
        end else if (slot_ready) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_valid && in_ready) begin
            slot_data <= in_data;
            slot_keep <= in_keep;
            slot_last <= in_last;
            slot_tid  <= in_tid;
        end
    end

    // ----------------------------------------
    // two-way demux
    // ----------------------------------------
    assign main_valid = slot_valid && !slot_aux;
    assign main_data  = slot_data;
    assign main_keep  = slot_keep;
    assign main_last  = slot_last;
    assign main_tid   = slot_tid;

    assign aux_valid  = slot_valid && slot_aux;
    assign aux_data   = slot_data;
    assign aux_keep   = slot_keep;
    assign aux_last   = slot_last;
    assign aux_tid    = slot_tid;

endmodule

`default_nettype wire

// File: smartnic_host.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_host_consts.svh"

module smartnic_host (
    input  logic                        core_clk,
    input  logic                        srst,

    input  logic                        host_valid,
    output logic                        host_ready,
    input  logic [`DATA_W-1:0]          host_data,
    input  logic [`KEEP_W-1:0]          host_keep,
    input  logic                        host_last,
    input  logic [`QID_W-1:0]           host_qid,

    input  logic                        pb_valid,
    output logic                        pb_ready,
    input  logic [`DATA_W-1:0]          pb_data,
    input  logic [`KEEP_W-1:0]          pb_keep,
    input  logic                        pb_last,
    input  smartnic_host_pkg::port_t    pb_tid,

    output logic                        core_main_valid,
    input  logic                        core_main_ready,
    output logic [`DATA_W-1:0]          core_main_data,
    output logic [`KEEP_W-1:0]          core_main_keep,
    output logic                        core_main_last,
    output smartnic_host_pkg::port_t    core_main_tid,

    output logic                        core_aux_valid,
    input  logic                        core_aux_ready,
    output logic [`DATA_W-1:0]          core_aux_data,
    output logic [`KEEP_W-1:0]          core_aux_keep,
    output logic                        core_aux_last,
    output smartnic_host_pkg::port_t    core_aux_tid,

    input  logic [`QID_W-1:0]           q_base [`NUM_RANGES],
    input  logic [`QID_W-1:0]           q_num  [`NUM_RANGES],
    output logic [`FAIL_CNT_W-1:0]      fail_cnt
);

    // classified host stream
    logic                       cls_valid;
    logic                       cls_ready;
    logic [`DATA_W-1:0]         cls_data;
    logic [`KEEP_W-1:0]         cls_keep;
    logic                       cls_last;
    smartnic_host_pkg::port_t   cls_tid;

    // merged stream into the steer
    logic                       arb_valid;
    logic                       arb_ready;
    logic [`DATA_W-1:0]         arb_data;
    logic [`KEEP_W-1:0]         arb_keep;
    logic                       arb_last;
    smartnic_host_pkg::port_t   arb_tid;

    // ----------------------------------------
    // host queue classifier, cmac port 0
    // ----------------------------------------
    host_q_classify #(
        .HOST_PORT (0)
    ) u_classify (
        .core_clk  (core_clk),
        .srst      (srst),
        .in_valid  (host_valid),
        .in_ready  (host_ready),
        .in_data   (host_data),
        .in_keep   (host_keep),
        .in_last   (host_last),
        .in_qid    (host_qid),
        .q_base    (q_base),
        .q_num     (q_num),
        .out_valid (cls_valid),
        .out_ready (cls_ready),
        .out_data  (cls_data),
        .out_keep  (cls_keep),
        .out_last  (cls_last),
        .out_tid   (cls_tid),
        .fail_cnt  (fail_cnt)
    );

    // host on input a, playback on input b
    pkt_arb_mux u_arb (
        .core_clk  (core_clk),
        .srst      (srst),
        .a_valid   (cls_valid),
        .a_ready   (cls_ready),
        .a_data    (cls_data),
        .a_keep    (cls_keep),
        .a_last    (cls_last),
        .a_tid     (cls_tid),
        .b_valid   (pb_valid),
        .b_ready   (pb_ready),
        .b_data    (pb_data),
        .b_keep    (pb_keep),
        .b_last    (pb_last),
        .b_tid     (pb_tid),
        .out_valid (arb_valid),
        .out_ready (arb_ready),
        .out_data  (arb_data),
        .out_keep  (arb_keep),
        .out_last  (arb_last),
        .out_tid   (arb_tid)
    );

    // ----------------------------------------
    // steer to main or aux core output
    // ----------------------------------------
    host_core_steer u_steer (
        .core_clk   (core_clk),
        .srst       (srst),
        .in_valid   (arb_valid),
        .in_ready   (arb_ready),
        .in_data    (arb_data),
        .in_keep    (arb_keep),
        .in_last    (arb_last),
        .in_tid     (arb_tid),
        .main_valid (core_main_valid),
        .main_ready (core_main_ready),
        .main_data  (core_main_data),
        .main_keep  (core_main_keep),
        .main_last  (core_main_last),
        .main_tid   (core_main_tid),
        .aux_valid  (core_aux_valid),
        .aux_ready  (core_aux_ready),
        .aux_data   (core_aux_data),
        .aux_keep   (core_aux_keep),
        .aux_last   (core_aux_last),
        .aux_tid    (core_aux_tid)
    );

endmodule

`default_nettype wire

// File: smartnic_host_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_host_consts.svh"

module smartnic_host_chk (
    input logic                        core_clk,
    input logic                        srst,
    input logic                        core_main_valid,
    input logic                        core_main_ready,
    input logic [`DATA_W-1:0]          core_main_data,
    input logic [`KEEP_W-1:0]          core_main_keep,
    input logic                        core_main_last,
    input smartnic_host_pkg::port_t    core_main_tid,
    input logic                        core_aux_valid,
    input logic                        core_aux_ready,
    input logic [`DATA_W-1:0]          core_aux_data,
    input logic [`KEEP_W-1:0]          core_aux_keep,
    input logic                        core_aux_last,
    input smartnic_host_pkg::port_t    core_aux_tid
);

    // ----------------------------------------
    // stall stability on the core outputs
    // ----------------------------------------
    main_hold: assert property (@(posedge core_clk) disable iff (srst)
        core_main_valid && !core_main_ready |=>
            core_main_valid && $stable(core_main_data) && $stable(core_main_keep) &&
            $stable(core_main_last) && $stable(core_main_tid))
        else $error("core_main beat changed while stalled");

    aux_hold: assert property (@(posedge core_clk) disable iff (srst)
        core_aux_valid && !core_aux_ready |=>
            core_aux_valid && $stable(core_aux_data) && $stable(core_aux_keep) &&
            $stable(core_aux_last) && $stable(core_aux_tid))
        else $error("core_aux beat changed while stalled");

    // outputs quiet once reset has been seen
    rst_quiet: assert property (@(posedge core_clk)
        srst |=> !core_main_valid && !core_aux_valid)
        else $error("core output valid during reset");

endmodule

bind smartnic_host smartnic_host_chk chk0 (.*);

`default_nettype wire

// File: smartnic_host_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "smartnic_host_consts.svh"

module smartnic_host_tb;

    localparam int TIMEOUT = 2000;

    logic                       core_clk = 1'b0;
    logic                       srst;
    logic                       host_valid;
    logic                       host_ready;
    logic [`DATA_W-1:0]         host_data;
    logic [`KEEP_W-1:0]         host_keep;
    logic                       host_last;
    logic [`QID_W-1:0]          host_qid;
    logic                       pb_valid;
    logic                       pb_ready;
    logic [`DATA_W-1:0]         pb_data;
    logic [`KEEP_W-1:0]         pb_keep;
    logic                       pb_last;
    smartnic_host_pkg::port_t   pb_tid;
    logic                       core_main_valid;
    logic                       core_main_ready;
    logic [`DATA_W-1:0]         core_main_data;
    logic [`KEEP_W-1:0]         core_main_keep;
    logic                       core_main_last;
    smartnic_host_pkg::port_t   core_main_tid;
    logic                       core_aux_valid;
    logic                       core_aux_ready;
    logic [`DATA_W-1:0]         core_aux_data;
    logic [`KEEP_W-1:0]         core_aux_keep;
    logic                       core_aux_last;
    smartnic_host_pkg::port_t   core_aux_tid;
    logic [`QID_W-1:0]          q_base [`NUM_RANGES];
    logic [`QID_W-1:0]          q_num  [`NUM_RANGES];
    logic [`FAIL_CNT_W-1:0]     fail_cnt;

    // stimulus beats waiting for the drivers
    logic [`DATA_W-1:0]         hq_data [$];
    logic [`KEEP_W-1:0]         hq_keep [$];
    logic                       hq_last [$];
    logic [`QID_W-1:0]          hq_qid  [$];
    logic [`DATA_W-1:0]         pq_data [$];
    logic [`KEEP_W-1:0]         pq_keep [$];
    logic                       pq_last [$];
    smartnic_host_pkg::port_t   pq_tid  [$];

    // predicted and collected beats, aux flag marks the output
    logic [`DATA_W-1:0]         exp_data [$];
    logic [`KEEP_W-1:0]         exp_keep [$];
    logic                       exp_last [$];
    smartnic_host_pkg::port_t   exp_tid  [$];
    logic                       exp_aux  [$];
    logic [`DATA_W-1:0]         got_data [$];
    logic [`KEEP_W-1:0]         got_keep [$];
    logic                       got_last [$];
    smartnic_host_pkg::port_t   got_tid  [$];
    logic                       got_aux  [$];

    // discarded packets sent since reset
    logic [`FAIL_CNT_W-1:0]     exp_fail_cnt;

    int got_base;
    int err_cnt;
    int errs_at_start;
    int tests_run;
    int tests_failed;

    smartnic_host dut0 (.*);

    always #20 core_clk = ~core_clk;

    // inputs only change 2 ns after the edge, so negedge sees settled handshakes
    always @(negedge core_clk) begin
        if (core_main_valid && core_main_ready) begin
            got_data.push_back(core_main_data);
            got_keep.push_back(core_main_keep);
            got_last.push_back(core_main_last);
            got_tid.push_back(core_main_tid);
            got_aux.push_back(1'b0);
        end
        if (core_aux_valid && core_aux_ready) begin
            got_data.push_back(core_aux_data);
            got_keep.push_back(core_aux_keep);
            got_last.push_back(core_aux_last);
            got_tid.push_back(core_aux_tid);
            got_aux.push_back(1'b1);
        end
    end

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("test failed");
        $finish;
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_beat(
        input string                    name,
        input logic [`DATA_W-1:0]       exp_d,
        input logic [`DATA_W-1:0]       got_d,
        input logic [`KEEP_W-1:0]       exp_k,
        input logic [`KEEP_W-1:0]       got_k,
        input logic                     exp_l,
        input logic                     got_l,
        input smartnic_host_pkg::port_t exp_t,
        input smartnic_host_pkg::port_t got_t
    );
        if (got_d !== exp_d) begin
            $display("ERR %s: data expected %h actual %h", name, exp_d, got_d);
            err_cnt++;
        end
        if (got_k !== exp_k) begin
            $display("ERR %s: keep expected %h actual %h", name, exp_k, got_k);
            err_cnt++;
        end
        if (got_l !== exp_l) begin
            $display("ERR %s: last expected %b actual %b", name, exp_l, got_l);
            err_cnt++;
        end
        if (got_t !== exp_t) begin
            $display("ERR %s: tid expected %b actual %b", name, exp_t.raw, got_t.raw);
            err_cnt++;
        end
    endtask

    task automatic check_count(
        input string                    name,
        input logic [`FAIL_CNT_W-1:0]   exp_c,
        input logic [`FAIL_CNT_W-1:0]   got_c
    );
        if (got_c !== exp_c) begin
            $display("ERR %s: fail_cnt expected %0d actual %0d", name, exp_c, got_c);
            err_cnt++;
        end
    endtask

    // walk one output's beats in order against its predicted beats
    task automatic check_output(input string name, input logic aux_sel);
        int gi;
        gi = got_base;
        for (int ei = 0; ei < exp_data.size(); ei++) begin
            if (exp_aux[ei] == aux_sel) begin
                while (gi < got_data.size() && got_aux[gi] != aux_sel) begin
                    gi++;
                end
                if (gi >= got_data.size()) begin
                    $display("%s: beat %0d never came out of the %s output",
                             name, ei, aux_sel ? "aux" : "main");
                    err_cnt++;
                    return;
                end
                check_beat(name, exp_data[ei], got_data[gi], exp_keep[ei], got_keep[gi],
                           exp_last[ei], got_last[gi], exp_tid[ei], got_tid[gi]);
                gi++;
            end
        end
        while (gi < got_data.size()) begin
            if (got_aux[gi] == aux_sel) begin
                $display("%s: unexpected extra beat on the %s output",
                         name, aux_sel ? "aux" : "main");
                err_cnt++;
            end
            gi++;
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic push_expect(
        input logic [`DATA_W-1:0]       d,
        input logic [`KEEP_W-1:0]       k,
        input logic                     l,
        input smartnic_host_pkg::port_t t
    );
        exp_data.push_back(d);
        exp_keep.push_back(k);
        exp_last.push_back(l);
        exp_tid.push_back(t);
        exp_aux.push_back(t.encoded.typ == smartnic_host_pkg::VF2);
    endtask

    task automatic add_host_pkt(
        input logic [`QID_W-1:0]            qid,
        input int                           beats,
        input logic                         hit,
        input smartnic_host_pkg::port_typ_e typ
    );
        logic [`DATA_W-1:0]         d;
        logic [`KEEP_W-1:0]         k;
        smartnic_host_pkg::port_t   t;
        t.encoded.num = smartnic_host_pkg::P0;
        t.encoded.typ = typ;
        for (int b = 0; b < beats; b++) begin
            d = {$urandom, $urandom};
            k = (b == beats - 1) ? ({`KEEP_W{1'b1}} >> ($urandom % 8)) : {`KEEP_W{1'b1}};
            hq_data.push_back(d);
            hq_keep.push_back(k);
            hq_last.push_back(b == beats - 1);
            hq_qid.push_back(qid);
            if (hit) begin
                push_expect(d, k, b == beats - 1, t);
            end
        end
        if (!hit) begin
            exp_fail_cnt++;
        end
    endtask

    task automatic add_pb_pkt(input smartnic_host_pkg::port_t t, input int beats);
        logic [`DATA_W-1:0] d;
        logic [`KEEP_W-1:0] k;
        for (int b = 0; b < beats; b++) begin
            d = {$urandom, $urandom};
            k = (b == beats - 1) ? ({`KEEP_W{1'b1}} >> ($urandom % 8)) : {`KEEP_W{1'b1}};
            pq_data.push_back(d);
            pq_keep.push_back(k);
            pq_last.push_back(b == beats - 1);
            pq_tid.push_back(t);
            push_expect(d, k, b == beats - 1, t);
        end
    endtask

    // drivers start and return 2 ns after a rising edge
    task automatic drive_host;
        int   t;
        logic fire;
        while (hq_data.size() > 0) begin
            host_valid = 1'b1;
            host_data  = hq_data.pop_front();
            host_keep  = hq_keep.pop_front();
            host_last  = hq_last.pop_front();
            host_qid   = hq_qid.pop_front();
            t    = 0;
            fire = 1'b0;
            while (!fire) begin
                @(negedge core_clk);
                fire = host_ready;
                @(posedge core_clk);
                #2;
                t++;
                if (!fire && t >= TIMEOUT) abort_run("host input never became ready");
            end
        end
        host_valid = 1'b0;
    endtask

    task automatic drive_pb;
        int   t;
        logic fire;
        while (pq_data.size() > 0) begin
            pb_valid = 1'b1;
            pb_data  = pq_data.pop_front();
            pb_keep  = pq_keep.pop_front();
            pb_last  = pq_last.pop_front();
            pb_tid   = pq_tid.pop_front();
            t    = 0;
            fire = 1'b0;
            while (!fire) begin
                @(negedge core_clk);
                fire = pb_ready;
                @(posedge core_clk);
                #2;
                t++;
                if (!fire && t >= TIMEOUT) abort_run("playback input never became ready");
            end
        end
        pb_valid = 1'b0;
    endtask

    // random core readies until every predicted beat is out
    task automatic shake_ready;
        int t;
        t = 0;
        while (got_data.size() - got_base < exp_data.size() && t < TIMEOUT) begin
            core_main_ready = ($urandom % 4) != 0;
            core_aux_ready  = ($urandom % 3) != 0;
            @(posedge core_clk);
            #2;
            t++;
        end
        core_main_ready = 1'b1;
        core_aux_ready  = 1'b1;
    endtask

    task automatic wait_drain(input string name);
        int t;
        t = 0;
        while (got_data.size() - got_base < exp_data.size()) begin
            @(posedge core_clk);
            t++;
            if (t >= TIMEOUT) abort_run({name, ": core outputs stopped short"});
        end
        // room for a stray extra beat
        repeat (8) @(posedge core_clk);
        #2;
    endtask

    task automatic start_test;
        exp_data.delete();
        exp_keep.delete();
        exp_last.delete();
        exp_tid.delete();
        exp_aux.delete();
        got_base      = got_data.size();
        errs_at_start = err_cnt;
    endtask

    task automatic finish_test(input string name);
        check_output(name, 1'b0);
        check_output(name, 1'b1);
        check_count(name, exp_fail_cnt, fail_cnt);
        tests_run++;
        if (err_cnt == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_classify;
        start_test();
        add_host_pkt(12'd3, 2, 1'b1, smartnic_host_pkg::PF);
        add_host_pkt(12'd20, 3, 1'b1, smartnic_host_pkg::VF0);
        add_host_pkt(12'd33, 1, 1'b1, smartnic_host_pkg::VF1);
        add_host_pkt(12'd50, 2, 1'b1, smartnic_host_pkg::VF2);
        drive_host();
        wait_drain("classify");
        finish_test("classify");
    endtask

    // ranges 2 and 3 share 40..47
    task automatic test_overlap;
        start_test();
        add_host_pkt(12'd44, 2, 1'b1, smartnic_host_pkg::VF1);
        add_host_pkt(12'd40, 1, 1'b1, smartnic_host_pkg::VF1);
        add_host_pkt(12'd47, 2, 1'b1, smartnic_host_pkg::VF1);
        add_host_pkt(12'd48, 1, 1'b1, smartnic_host_pkg::VF2);
        drive_host();
        wait_drain("overlap");
        finish_test("overlap");
    endtask

    task automatic test_range_fail;
        logic [`QID_W-1:0] bad_ids [4];
        bad_ids = '{12'd8, 12'd24, 12'd100, 12'd4095};
        start_test();
        for (int i = 0; i < 4; i++) begin
            add_host_pkt(bad_ids[i], 1 + i % 3, 1'b0, smartnic_host_pkg::PF);
        end
        // one good packet behind them marks the end
        add_host_pkt(12'd0, 2, 1'b1, smartnic_host_pkg::PF);
        drive_host();
        wait_drain("range_fail");
        finish_test("range_fail");
    endtask

    // playback reaches the arbiter a cycle ahead of the host register
    task automatic test_arbitration;
        smartnic_host_pkg::port_t t;
        start_test();
        t.raw = 3'b100;
        add_pb_pkt(t, 3);
        add_host_pkt(12'd1, 3, 1'b1, smartnic_host_pkg::PF);
        t.raw = 3'b111;
        add_pb_pkt(t, 3);
        add_host_pkt(12'd17, 3, 1'b1, smartnic_host_pkg::VF0);
        t.raw = 3'b110;
        add_pb_pkt(t, 3);
        add_host_pkt(12'd35, 3, 1'b1, smartnic_host_pkg::VF1);
        fork
            drive_host();
            drive_pb();
        join
        wait_drain("arbitration");
        finish_test("arbitration");
    endtask

    task automatic test_backpressure;
        smartnic_host_pkg::port_t t;
        int                       sel;
        start_test();
        for (int i = 0; i < 5; i++) begin
            if (i < 3) begin
                t.raw = 3'(4 + $urandom % 4);
                add_pb_pkt(t, 1 + $urandom % 4);
            end
            sel = $urandom % 4;
            case (sel)
                0: add_host_pkt(12'd2, 1 + $urandom % 4, 1'b1, smartnic_host_pkg::PF);
                1: add_host_pkt(12'd18, 1 + $urandom % 4, 1'b1, smartnic_host_pkg::VF0);
                2: add_host_pkt(12'd36, 1 + $urandom % 4, 1'b1, smartnic_host_pkg::VF1);
                default: add_host_pkt(12'd52, 1 + $urandom % 4, 1'b1, smartnic_host_pkg::VF2);
            endcase
        end
        fork
            drive_host();
            drive_pb();
            shake_ready();
        join
        wait_drain("backpressure");
        finish_test("backpressure");
    endtask

    initial begin
        void'($urandom(32'he42b_5c9d));
        srst            = 1'b1;
        host_valid      = 1'b0;
        host_data       = '0;
        host_keep       = '0;
        host_last       = 1'b0;
        host_qid        = '0;
        pb_valid        = 1'b0;
        pb_data         = '0;
        pb_keep         = '0;
        pb_last         = 1'b0;
        pb_tid          = '0;
        core_main_ready = 1'b1;
        core_aux_ready  = 1'b1;
        // PF 0..7, VF0 16..23, VF1 32..47, VF2 40..63
        q_base          = '{12'd0, 12'd16, 12'd32, 12'd40};
        q_num           = '{12'd8, 12'd8, 12'd16, 12'd24};
        exp_fail_cnt    = '0;
        got_base        = 0;
        err_cnt         = 0;
        errs_at_start   = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (10) @(posedge core_clk);
        #2;
        srst = 1'b0;
        test_classify();
        test_overlap();
        test_range_fail();
        test_arbitration();
        test_backpressure();
        $display("summary: %0d run, %0d failing, %0d errors", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
smartnic_host_pkg.sv
host_q_classify.sv
pkt_arb_mux.sv
host_core_steer.sv
smartnic_host.sv
smartnic_host_chk.sv
smartnic_host_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the smartnic_host testbench with verilator
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module smartnic_host_tb -f flist.f -o smartnic_host_sim &&
./obj_dir/smartnic_host_sim | tee /dev/stderr | grep -q "^test passed$" &&
echo "simulation ok" || { echo "simulation FAILED"; exit 1; }
